// File: common/voice_pkg.sv
// Shared mode and buffer-state enums plus default sizing values for the voice effect stage.
`default_nettype none

package voice_pkg;

    // Effect mode, held constant while out of reset.
    typedef enum logic [1:0]
    {
        mode_normal = 2'd0,
        mode_lower  = 2'd1,
        mode_raise  = 2'd2
    } mode_e;

    // Read side of the ping-pong buffer.
    typedef enum logic [1:0]
    {
        st_prime = 2'd0,
        st_run   = 2'd1,
        st_wait  = 2'd2
    } buf_state_e;

    // Default sample and bank address widths.
    localparam int DEF_DATA_WIDTH = 8;
    localparam int DEF_ADDR_WIDTH = 8;

    // Default read intervals in sck cycles.
    localparam int DEF_LOWER_DIV  = 64;
    localparam int DEF_RAISE_DIV  = 16;

endpackage

`default_nettype wire

// File: logic/sample_router.sv
// Sample router with per-channel write pointers, full flags, write strobes and ready outputs.
`timescale 1ns/1ps
`default_nettype none

module sample_router
    import voice_pkg::*;
#(
    parameter int DATA_WIDTH = DEF_DATA_WIDTH,
    parameter int ADDR_WIDTH = DEF_ADDR_WIDTH
)
(
    input  wire logic                  sck,
    input  wire logic                  rst_n,
    input  wire mode_e                 mode,
    input  wire logic                  l_vld,
    input  wire logic                  r_vld,
    input  wire logic                  bank_swap,
    output logic                       l_rdy,
    output logic                       r_rdy,
    output logic                       l_wr_en,
    output logic                       r_wr_en,
    output logic [ADDR_WIDTH-1:0]      l_wr_addr,
    output logic [ADDR_WIDTH-1:0]      r_wr_addr,
    output logic                       banks_full
);

    localparam logic [ADDR_WIDTH-1:0] LAST_ADDR = '1;

    logic pitch;
    logic l_full;
    logic r_full;

    // Bank sizing sanity check at elaboration.
    if (DATA_WIDTH < 1 || ADDR_WIDTH < 1)
    begin : g_param_check
        $error("sample_router needs positive DATA_WIDTH and ADDR_WIDTH.");
    end

    assign pitch = (mode != mode_normal);

    // Pass-through never stalls the source.
    assign l_rdy = !pitch || !l_full;
    assign r_rdy = !pitch || !r_full;

    assign l_wr_en = pitch && l_vld && !l_full;
    assign r_wr_en = pitch && r_vld && !r_full;

    assign banks_full = l_full && r_full;

    // Write pointers and full flags per channel.
    always_ff @(posedge sck or negedge rst_n)
    begin
        if (!rst_n)
        begin
            l_wr_addr <= '0;
            r_wr_addr <= '0;
            l_full    <= 1'b0;
            r_full    <= 1'b0;
        end
        else if (bank_swap)
        begin
            // Fresh write bank after the swap.
            l_wr_addr <= '0;
            r_wr_addr <= '0;
            l_full    <= 1'b0;
            r_full    <= 1'b0;
        end
        else
        begin
            if (l_wr_en)
            begin
                l_wr_addr <= l_wr_addr + 1'b1;
                l_full    <= (l_wr_addr == LAST_ADDR);
            end
            if (r_wr_en)
            begin
                r_wr_addr <= r_wr_addr + 1'b1;
                r_full    <= (r_wr_addr == LAST_ADDR);
            end
        end
    end

    // Mode may only change under reset.
    a_mode_stable: assert property (@(posedge sck) disable iff (!rst_n) $stable(mode));

    // Shared data bus carries one channel per cycle.
    a_one_valid: assert property (@(posedge sck) disable iff (!rst_n) !(l_vld && r_vld));

endmodule

`default_nettype wire

// File: pitch_buffer/pitch_buffer.sv
// Ping-pong sample banks with read pacer, read pointer and bank swap FSM.
`timescale 1ns/1ps
`default_nettype none

module pitch_buffer
    import voice_pkg::*;
#(
    parameter int DATA_WIDTH = DEF_DATA_WIDTH,
    parameter int ADDR_WIDTH = DEF_ADDR_WIDTH,
    parameter int LOWER_DIV  = DEF_LOWER_DIV,
    parameter int RAISE_DIV  = DEF_RAISE_DIV
)
(
    input  wire logic                  sck,
    input  wire logic                  rst_n,
    input  wire mode_e                 mode,
    input  wire logic [DATA_WIDTH-1:0] data,
    input  wire logic                  l_wr_en,
    input  wire logic                  r_wr_en,
    input  wire logic [ADDR_WIDTH-1:0] l_wr_addr,
    input  wire logic [ADDR_WIDTH-1:0] r_wr_addr,
    input  wire logic                  banks_full,
    output logic                       bank_swap,
    output logic                       rd_vld,
    output logic [DATA_WIDTH-1:0]      rd_l,
    output logic [DATA_WIDTH-1:0]      rd_r
);

    localparam int DEPTH   = 1 << ADDR_WIDTH;
    localparam int MAX_DIV = (LOWER_DIV > RAISE_DIV) ? LOWER_DIV : RAISE_DIV;
    localparam int CNT_W   = $clog2(MAX_DIV + 1);
    localparam logic [ADDR_WIDTH-1:0] LAST_ADDR = '1;

    // Two banks per channel, indexed by bank select.
    logic [DATA_WIDTH-1:0] l_mem [2][DEPTH];
    logic [DATA_WIDTH-1:0] r_mem [2][DEPTH];

    logic                  wr_sel;
    logic                  rd_sel;
    logic [ADDR_WIDTH-1:0] rd_ptr;
    logic [CNT_W-1:0]      pace_cnt;
    logic [CNT_W-1:0]      pace_last;
    logic                  tick;
    buf_state_e            state;

    // Reads always come from the bank not being written.
    assign rd_sel = ~wr_sel;

    always_ff @(posedge sck)
    begin
        if (l_wr_en)
            l_mem[wr_sel][l_wr_addr] <= data;
        if (r_wr_en)
            r_mem[wr_sel][r_wr_addr] <= data;
    end

    // Read interval depends on the effect.
    assign pace_last = (mode == mode_raise) ? CNT_W'(RAISE_DIV - 1) : CNT_W'(LOWER_DIV - 1);
    assign tick      = (state == st_run) && (pace_cnt == pace_last);

    // Pacer only runs while draining a bank.
    always_ff @(posedge sck or negedge rst_n)
    begin
        if (!rst_n)
            pace_cnt <= '0;
        else if (state != st_run || tick)
            pace_cnt <= '0;
        else
            pace_cnt <= pace_cnt + 1'b1;
    end

    // Left and right pair read on each tick.
    always_ff @(posedge sck)
    begin
        if (tick)
        begin
            rd_l <= l_mem[rd_sel][rd_ptr];
            rd_r <= r_mem[rd_sel][rd_ptr];
        end
    end

    // Swap control and read pointer.
    always_ff @(posedge sck or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= st_prime;
            wr_sel    <= 1'b0;
            rd_ptr    <= '0;
            bank_swap <= 1'b0;
            rd_vld    <= 1'b0;
        end
        else
        begin
            bank_swap <= 1'b0;
            rd_vld    <= tick;
            case (state)
                st_prime, st_wait:
                begin
                    // Both write banks filled, so hand them to the read side.
                    if (banks_full)
                    begin
                        bank_swap <= 1'b1;
                        wr_sel    <= ~wr_sel;
                        rd_ptr    <= '0;
                        state     <= st_run;
                    end
                end
                st_run:
                begin
                    if (tick)
                    begin
                        rd_ptr <= rd_ptr + 1'b1;
                        if (rd_ptr == LAST_ADDR)
                            state <= st_wait;
                    end
                end
                default:
                    state <= st_prime;
            endcase
        end
    end

    // Swap pulse is only issued against full write banks.
    a_swap_needs_full: assert property (@(posedge sck) disable iff (!rst_n)
        bank_swap |-> banks_full);

    // The router must release its banks right after a swap.
    a_swap_clears_full: assert property (@(posedge sck) disable iff (!rst_n)
        bank_swap |=> !banks_full);

endmodule

`default_nettype wire

// File: logic/output_stage.sv
// Output stage selecting pass-through or buffered samples, with registered data and valids.
`timescale 1ns/1ps
`default_nettype none

module output_stage
    import voice_pkg::*;
#(
    parameter int DATA_WIDTH = DEF_DATA_WIDTH
)
(
    input  wire logic                  sck,
    input  wire logic                  rst_n,
    input  wire mode_e                 mode,
    input  wire logic [DATA_WIDTH-1:0] data,
    input  wire logic                  l_vld,
    input  wire logic                  r_vld,
    input  wire logic                  rd_vld,
    input  wire logic [DATA_WIDTH-1:0] rd_l,
    input  wire logic [DATA_WIDTH-1:0] rd_r,
    output logic [DATA_WIDTH-1:0]      ldata,
    output logic [DATA_WIDTH-1:0]      rdata,
    output logic                       l_out_vld,
    output logic                       r_out_vld
);

    logic pitch;

    assign pitch = (mode != mode_normal);

    always_ff @(posedge sck or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ldata     <= '0;
            rdata     <= '0;
            l_out_vld <= 1'b0;
            r_out_vld <= 1'b0;
        end
        else if (!pitch)
        begin
            // Each channel updates only on its own strobe.
            l_out_vld <= l_vld;
            r_out_vld <= r_vld;
            if (l_vld)
                ldata <= data;
            if (r_vld)
                rdata <= data;
        end
        else
        begin
            // Buffered pairs leave together.
            l_out_vld <= rd_vld;
            r_out_vld <= rd_vld;
            if (rd_vld)
            begin
                ldata <= rd_l;
                rdata <= rd_r;
            end
        end
    end

    // The buffer stays idle in pass-through.
    a_no_read_normal: assert property (@(posedge sck) disable iff (!rst_n)
        (mode == mode_normal) |-> !rd_vld);

endmodule

`default_nettype wire

// File: logic/voice_changer_top.sv
// Top level of the voice effect stage with router, pitch buffer and output stage.
`timescale 1ns/1ps
`default_nettype none

module voice_changer_top
    import voice_pkg::*;
#(
    parameter int DATA_WIDTH = DEF_DATA_WIDTH,
    parameter int ADDR_WIDTH = DEF_ADDR_WIDTH,
    parameter int LOWER_DIV  = DEF_LOWER_DIV,
    parameter int RAISE_DIV  = DEF_RAISE_DIV
)
(
    input  wire logic                  sck,
    input  wire logic                  rst_n,
    input  wire mode_e                 mode,
    input  wire logic [DATA_WIDTH-1:0] data,
    input  wire logic                  l_vld,
    input  wire logic                  r_vld,
    output logic                       l_rdy,
    output logic                       r_rdy,
    output logic [DATA_WIDTH-1:0]      ldata,
    output logic [DATA_WIDTH-1:0]      rdata,
    output logic                       l_out_vld,
    output logic                       r_out_vld
);

    logic                  l_wr_en;
    logic                  r_wr_en;
    logic [ADDR_WIDTH-1:0] l_wr_addr;
    logic [ADDR_WIDTH-1:0] r_wr_addr;
    logic                  banks_full;
    logic                  bank_swap;
    logic                  rd_vld;
    logic [DATA_WIDTH-1:0] rd_l;
    logic [DATA_WIDTH-1:0] rd_r;

    sample_router #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_sample_router (
        .sck        (sck),
        .rst_n      (rst_n),
        .mode       (mode),
        .l_vld      (l_vld),
        .r_vld      (r_vld),
        .bank_swap  (bank_swap),
        .l_rdy      (l_rdy),
        .r_rdy      (r_rdy),
        .l_wr_en    (l_wr_en),
        .r_wr_en    (r_wr_en),
        .l_wr_addr  (l_wr_addr),
        .r_wr_addr  (r_wr_addr),
        .banks_full (banks_full)
    );

    pitch_buffer #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH),
        .LOWER_DIV  (LOWER_DIV),
        .RAISE_DIV  (RAISE_DIV)
    ) u_pitch_buffer (
        .sck        (sck),
        .rst_n      (rst_n),
        .mode       (mode),
        .data       (data),
        .l_wr_en    (l_wr_en),
        .r_wr_en    (r_wr_en),
        .l_wr_addr  (l_wr_addr),
        .r_wr_addr  (r_wr_addr),
        .banks_full (banks_full),
        .bank_swap  (bank_swap),
        .rd_vld     (rd_vld),
        .rd_l       (rd_l),
        .rd_r       (rd_r)
    );

    output_stage #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_output_stage (
        .sck        (sck),
        .rst_n      (rst_n),
        .mode       (mode),
        .data       (data),
        .l_vld      (l_vld),
        .r_vld      (r_vld),
        .rd_vld     (rd_vld),
        .rd_l       (rd_l),
        .rd_r       (rd_r),
        .ldata      (ldata),
        .rdata      (rdata),
        .l_out_vld  (l_out_vld),
        .r_out_vld  (r_out_vld)
    );

endmodule

`default_nettype wire

// File: testbench/tb_voice_changer.sv
// Testbench for the voice effect stage with vector reader, driver, scoreboard and timeout.
`timescale 1ns/1ps
`default_nettype none

module tb_voice_changer
    import voice_pkg::*;
();

    localparam int DW      = 8;
    localparam int AW      = 3;
    localparam int L_DIV   = 6;
    localparam int R_DIV   = 4;
    localparam int BANK    = 1 << AW;
    localparam int MAX_DIV = (L_DIV > R_DIV) ? L_DIV : R_DIV;

    logic          sck;
    logic          rst_n;
    mode_e         mode;
    logic [DW-1:0] data;
    logic          l_vld;
    logic          r_vld;
    logic          l_rdy;
    logic          r_rdy;
    logic [DW-1:0] ldata;
    logic [DW-1:0] rdata;
    logic          l_out_vld;
    logic          r_out_vld;

    // Vector table and scoreboard.
    int            vec_test[$];
    int            vec_mode[$];
    int            vec_chan[$];
    logic [DW-1:0] vec_data[$];
    logic [DW-1:0] exp_l[$];
    logic [DW-1:0] exp_r[$];
    int            acc_l;
    int            acc_r;
    int            outs_l;
    int            outs_r;
    int            stalls;
    int            errors;
    int            cycles;
    int            cycle_limit;
    int            cur_test;
    int            cur_div;
    // Cycles since the previous output pair, negative before the first one.
    int            out_gap;
    logic          l_acc_prev;
    logic          r_acc_prev;
    logic [DW-1:0] l_hold;
    logic [DW-1:0] r_hold;
    logic          checking;

    voice_changer_top #(
        .DATA_WIDTH (DW),
        .ADDR_WIDTH (AW),
        .LOWER_DIV  (L_DIV),
        .RAISE_DIV  (R_DIV)
    ) DUT (
        .sck        (sck),
        .rst_n      (rst_n),
        .mode       (mode),
        .data       (data),
        .l_vld      (l_vld),
        .r_vld      (r_vld),
        .l_rdy      (l_rdy),
        .r_rdy      (r_rdy),
        .ldata      (ldata),
        .rdata      (rdata),
        .l_out_vld  (l_out_vld),
        .r_out_vld  (r_out_vld)
    );

    always #20 sck = ~sck;

    task automatic compare_hex(input string name, input logic [DW-1:0] exp,
                               input logic [DW-1:0] act);
        assert (act === exp)
        else
        begin
            $display("ERROR %s expected %h actual %h in test %0d", name, exp, act, cur_test);
            errors++;
        end
    endtask

    task automatic expect_rule(input logic ok, input string what);
        assert (ok)
        else
        begin
            $display("Test %0d went wrong: %s", cur_test, what);
            errors++;
        end
    endtask

    // Run length guard.
    always @(posedge sck)
    begin
        cycles++;
        if (cycles >= cycle_limit)
        begin
            $display("Timeout after %0d cycles while test %0d was running", cycles, cur_test);
            $display("Simulation failed");
            $finish;
        end
    end

    // Scoreboard, sampled on the rising edge before the DUT registers update.
    always @(posedge sck)
    begin
        if (checking)
        begin
            if (mode == mode_normal)
            begin
                expect_rule(l_rdy && r_rdy, "ready dropped in pass-through");
                expect_rule(l_out_vld == l_acc_prev, "left valid does not follow its input");
                expect_rule(r_out_vld == r_acc_prev, "right valid does not follow its input");
                if (!l_out_vld)
                    compare_hex("ldata", l_hold, ldata);
                if (!r_out_vld)
                    compare_hex("rdata", r_hold, rdata);
            end
            else
            begin
                expect_rule(l_out_vld == r_out_vld, "left and right outputs are not paired");
                if (out_gap >= 0)
                    out_gap++;
                if (l_out_vld)
                begin
                    expect_rule(acc_l >= BANK && acc_r >= BANK, "output before a bank filled");
                    if (out_gap >= 0)
                        expect_rule(out_gap >= cur_div, "outputs too close together");
                    out_gap = 0;
                end
            end
            if (l_out_vld)
            begin
                if (exp_l.size() == 0)
                    expect_rule(1'b0, "left output with no accepted sample left");
                else
                    compare_hex("ldata", exp_l.pop_front(), ldata);
                outs_l++;
            end
            if (r_out_vld)
            begin
                if (exp_r.size() == 0)
                    expect_rule(1'b0, "right output with no accepted sample left");
                else
                    compare_hex("rdata", exp_r.pop_front(), rdata);
                outs_r++;
            end
            if ((l_vld && !l_rdy) || (r_vld && !r_rdy))
                stalls++;
            if (l_vld && l_rdy)
            begin
                exp_l.push_back(data);
                acc_l++;
            end
            if (r_vld && r_rdy)
            begin
                exp_r.push_back(data);
                acc_r++;
            end
            l_acc_prev = l_vld && l_rdy;
            r_acc_prev = r_vld && r_rdy;
            l_hold     = ldata;
            r_hold     = rdata;
        end
    end

    initial
    begin
        int            fd;
        string         line;
        int            t;
        int            m;
        int            c;
        logic [DW-1:0] d;
        int            idx;
        int            n_tests;
        int            nv_l;
        int            nv_r;
        int            tgt_l;
        int            tgt_r;
        int            err_start;

        sck         = 1'b0;
        rst_n       = 1'b0;
        mode        = mode_normal;
        data        = '0;
        l_vld       = 1'b0;
        r_vld       = 1'b0;
        checking    = 1'b0;
        errors      = 0;
        cycles      = 0;
        cur_test    = 0;
        n_tests     = 0;
        cycle_limit = 1000;

        fd = $fopen("testbench/voice_vectors.txt", "r");
        if (fd == 0)
            expect_rule(1'b0, "vector file could not be opened");
        else
        begin
            while (!$feof(fd))
            begin
                if ($fgets(line, fd) != 0 && $sscanf(line, "%h %h %h %h", t, m, c, d) == 4)
                begin
                    vec_test.push_back(t);
                    vec_mode.push_back(m);
                    vec_chan.push_back(c);
                    vec_data.push_back(d);
                end
            end
            $fclose(fd);
        end
        // Every vector may wait out a full read interval several times.
        if (vec_test.size() > 0)
            cycle_limit = vec_test.size() * MAX_DIV * 4;

        idx = 0;
        while (idx < vec_test.size())
        begin
            cur_test  = vec_test[idx];
            err_start = errors;
            @(posedge sck);
            checking <= 1'b0;
            rst_n    <= 1'b0;
            mode     <= mode_e'(vec_mode[idx]);
            @(posedge sck);
            exp_l.delete();
            exp_r.delete();
            acc_l      = 0;
            acc_r      = 0;
            outs_l     = 0;
            outs_r     = 0;
            stalls     = 0;
            nv_l       = 0;
            nv_r       = 0;
            out_gap    = -1;
            l_acc_prev = 1'b0;
            r_acc_prev = 1'b0;
            l_hold     = '0;
            r_hold     = '0;
            cur_div    = (vec_mode[idx] == int'(mode_raise)) ? R_DIV : L_DIV;
            @(posedge sck);
            rst_n <= 1'b1;
            @(posedge sck);

            // Idle state right after reset.
            expect_rule(l_rdy && r_rdy, "ready is low after reset");
            expect_rule(!l_out_vld && !r_out_vld, "output valid is high after reset");
            compare_hex("ldata", '0, ldata);
            compare_hex("rdata", '0, rdata);

            checking <= 1'b1;
            while (idx < vec_test.size() && vec_test[idx] == cur_test)
            begin
                data  <= vec_data[idx];
                l_vld <= (vec_chan[idx] == 0);
                r_vld <= (vec_chan[idx] == 1);
                if (vec_chan[idx] == 0)
                    nv_l++;
                else
                    nv_r++;
                @(posedge sck);
                while (!((l_vld && l_rdy) || (r_vld && r_rdy)))
                    @(posedge sck);
                idx++;
            end
            l_vld <= 1'b0;
            r_vld <= 1'b0;
            @(posedge sck);

            // Only whole banks leave the buffer in the pitch modes.
            if (mode == mode_normal)
            begin
                tgt_l = acc_l;
                tgt_r = acc_r;
            end
            else
            begin
                tgt_l = BANK * (((acc_l < acc_r) ? acc_l : acc_r) / BANK);
                tgt_r = tgt_l;
            end
            while (outs_l < tgt_l || outs_r < tgt_r)
                @(posedge sck);
            // Quiet window catches duplicated outputs.
            repeat (2 * MAX_DIV) @(posedge sck);

            expect_rule(outs_l == tgt_l && outs_r == tgt_r,
                        "output count differs from the accepted samples");
            if (mode != mode_normal && (nv_l > BANK || nv_r > BANK))
                expect_rule(stalls > 0, "ready never dropped during a burst past one bank");
            $display("Test %0d %s: in/out left %0d/%0d right %0d/%0d, %0d stalls, %0d errors",
                     cur_test, mode.name(), acc_l, outs_l, acc_r, outs_r, stalls,
                     errors - err_start);
            n_tests++;
        end

        $display("Tests run %0d, vectors %0d, errors %0d", n_tests, vec_test.size(), errors);
        if (errors == 0 && n_tests > 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
common/voice_pkg.sv
logic/sample_router.sv
pitch_buffer/pitch_buffer.sv
logic/output_stage.sv
logic/voice_changer_top.sv
testbench/tb_voice_changer.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the voice effect testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log \
    && verilator --binary --timing --assert -Wno-fatal --top-module tb_voice_changer \
        -f build.f -o tb_voice_changer > build.log 2>&1 \
    && ./obj_dir/tb_voice_changer > sim.log 2>&1 \
    || echo "Build or simulation run stopped with an error, see build.log and sim.log"
grep -q "Simulation completed successfully" sim.log && echo "PASS" && exit 0 \
    || { echo "FAIL"; exit 1; }

// File: testbench/voice_vectors.txt
// Columns: test number, mode (0 normal, 1 lower, 2 raise), channel (0 left, 1 right),
// sample value. All fields in hex, one source sample per line.
1 0 0 a5
1 0 1 3c
1 0 0 5a
1 0 0 c3
2 1 0 10
2 1 1 20
2 1 0 11
2 1 1 21
2 1 0 12
2 1 1 22
2 1 0 13
2 1 1 23
2 1 0 14
2 1 1 24
2 1 0 15
2 1 1 25
2 1 0 16
2 1 1 26
2 1 0 17
2 1 1 27
3 2 0 40
3 2 1 80
3 2 0 41
3 2 1 81
3 2 0 42
3 2 1 82
3 2 0 43
3 2 1 83
3 2 0 44
3 2 1 84
3 2 0 45
3 2 1 85
3 2 0 46
3 2 1 86
3 2 0 47
3 2 1 87
3 2 0 48
3 2 1 88
